/* source/dma_params.svh */
// Data mover parameters
// Data path width, control word width and control word field positions

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Data path
`define DMA_DATA_W 64

// Control word
`define DMA_DC_W 24

// Operation field, bits 1 to 0
`define DMA_OP_LSB 0
`define DMA_OP_W 2

// Fill count, bits 23 to 8, zero acts as one
`define DMA_LEN_LSB 8
`define DMA_LEN_W 16

`endif

/* source/dma_pkg.sv */
// Data mover types
// Operation codes from the control word and controller states

`include "dma_params.svh"

package dma_pkg;

   // Operation field of the control word
   typedef enum logic [`DMA_OP_W-1:0] {
      OP_READ = 2'd0,
      OP_COPY = 2'd1,
      OP_FILL = 2'd2,
      OP_NONE = 2'd3
   } dma_op_e;

   // Controller sequence
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_HOLD
   } dma_state_e;

endpackage

/* source/dma_stream_if.sv */
// Word stream between data mover stages
// A word moves on an edge where valid and ready are both high

`timescale 1ns/10ps
`include "dma_params.svh"

interface dma_stream_if;

   logic [`DMA_DATA_W-1:0] data;
   logic                   last;
   logic                   valid;
   logic                   ready;

   // Producer side
   modport source (output data, last, valid, input ready);

   // Consumer side
   modport sink (input data, last, valid, output ready);

endinterface

/* source/dma_ctrl.sv */
// Data mover controller
// Latches the control word on enable, pulses start to the work stages
// and drives the one-cycle active-low end strobe on completion

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_ctrl import dma_pkg::*; (
   input  logic                  wb_clk_i,
   input  logic                  reset_i,
   input  logic                  enable_i,
   input  logic [`DMA_DC_W-1:0]  dc_i,
   input  logic                  src_done_i,
   input  logic                  put_last_i,
   output dma_op_e               op_o,
   output logic [`DMA_LEN_W-1:0] fill_len_o,
   output logic                  start_o,
   output logic                  m_endn_o
);

   dma_state_e state_q;
   logic       done;

   // Completion source per operation
   always_comb begin
      case (op_o)
         OP_READ: done = src_done_i;
         OP_NONE: done = start_o;
         default: done = put_last_i;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         state_q  <= ST_IDLE;
         op_o     <= OP_NONE;
         start_o  <= 1'b0;
         m_endn_o <= 1'b1;
      end else begin
         start_o  <= 1'b0;
         m_endn_o <= 1'b1;
         case (state_q)
            ST_IDLE: begin
               if (enable_i) begin
                  op_o    <= dma_op_e'(dc_i[`DMA_OP_LSB +: `DMA_OP_W]);
                  start_o <= 1'b1;
                  state_q <= ST_RUN;
               end
            end
            ST_RUN: begin
               // Enable dropping here is ignored until the job ends
               if (done) begin
                  m_endn_o <= 1'b0;
                  state_q  <= ST_HOLD;
               end
            end
            default: begin
               if (!enable_i) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // Fill count captured with the operation
   always_ff @(posedge wb_clk_i) begin
      if (state_q == ST_IDLE && enable_i) begin
         fill_len_o <= dc_i[`DMA_LEN_LSB +: `DMA_LEN_W];
      end
   end

   // One end strobe per job
   a_endn_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      !m_endn_o |=> m_endn_o);

endmodule

/* source/dma_src_engine.sv */
// Source FIFO engine
// Pops the show-ahead source FIFO per operation: copy forwards every word,
// fill forwards one pattern word and read drains to the last word

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_src_engine import dma_pkg::*; (
   input  logic                   wb_clk_i,
   input  logic                   reset_i,
   input  dma_op_e                op_i,
   input  logic                   start_i,
   input  logic [`DMA_DATA_W-1:0] m_src_i,
   input  logic                   m_src_last_i,
   input  logic                   m_src_empty_i,
   output logic                   m_src_getn_o,
   output logic                   src_done_o,
   dma_stream_if.source           out_if
);

   logic active_q;
   logic fwd;
   logic drain;
   logic pop;
   logic stop;

   // Copy and fill put source words on the stream, read only drains
   assign fwd   = (op_i == OP_COPY) || (op_i == OP_FILL);
   assign drain = active_q && (op_i == OP_READ) && !m_src_empty_i;

   assign out_if.valid = active_q && fwd && !m_src_empty_i;
   assign out_if.data  = m_src_i;
   assign out_if.last  = m_src_last_i;

   // Pop on the same edge the word moves
   assign pop  = (out_if.valid && out_if.ready) || drain;
   assign stop = pop && ((op_i == OP_FILL) || m_src_last_i);

   assign m_src_getn_o = ~pop;
   assign src_done_o   = drain && m_src_last_i;

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         active_q <= 1'b0;
      end else if (start_i) begin
         active_q <= (op_i != OP_NONE);
      end else if (stop) begin
         active_q <= 1'b0;
      end
   end

   // Show-ahead FIFO must never be popped while empty
   a_no_pop_empty: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      !m_src_getn_o |-> !m_src_empty_i);

endmodule

/* source/dma_fill_stage.sv */
// Fill stage
// Copy words pass straight through; in fill the single pattern word is
// captured and repeated for the programmed count, last on the final one

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_fill_stage import dma_pkg::*; (
   input  logic                  wb_clk_i,
   input  logic                  reset_i,
   input  dma_op_e               op_i,
   input  logic                  start_i,
   input  logic [`DMA_LEN_W-1:0] fill_len_i,
   dma_stream_if.sink            in_if,
   dma_stream_if.source          out_if
);

   logic                   is_fill;
   logic                   cap_q;
   logic                   rep_q;
   logic                   rep_last;
   logic [`DMA_DATA_W-1:0] pat_q;
   logic [`DMA_LEN_W-1:0]  cnt_q;

   assign is_fill  = (op_i == OP_FILL);
   assign rep_last = (cnt_q == `DMA_LEN_W'(1));

   always_comb begin
      if (is_fill) begin
         in_if.ready  = cap_q;
         out_if.valid = rep_q;
         out_if.data  = pat_q;
         out_if.last  = rep_last;
      end else begin
         in_if.ready  = out_if.ready;
         out_if.valid = in_if.valid;
         out_if.data  = in_if.data;
         out_if.last  = in_if.last;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         cap_q <= 1'b0;
         rep_q <= 1'b0;
         cnt_q <= '0;
      end else if (start_i && is_fill) begin
         cap_q <= 1'b1;
      end else if (cap_q && in_if.valid) begin
         // Pattern taken, repeats start next cycle
         cap_q <= 1'b0;
         rep_q <= 1'b1;
         cnt_q <= (fill_len_i == '0) ? `DMA_LEN_W'(1) : fill_len_i;
      end else if (rep_q && out_if.ready) begin
         cnt_q <= cnt_q - `DMA_LEN_W'(1);
         if (rep_last) begin
            rep_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (cap_q && in_if.valid) begin
         pat_q <= in_if.data;
      end
   end

   a_cnt_no_wrap: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      rep_q |-> (cnt_q != '0));

endmodule

/* source/dma_dst_writer.sv */
// Destination FIFO writer
// Holds one word in an output register and puts it one cycle after it
// was accepted; almost-full is treated as full since a word may be held

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_dst_writer (
   input  logic                   wb_clk_i,
   input  logic                   reset_i,
   input  logic                   m_dst_full_i,
   input  logic                   m_dst_almost_full_i,
   dma_stream_if.sink             in_if,
   output logic [`DMA_DATA_W-1:0] m_dst_o,
   output logic                   m_dst_last_o,
   output logic                   m_dst_putn_o,
   output logic                   put_last_o
);

   logic                   pend_q;
   logic [`DMA_DATA_W-1:0] data_q;
   logic                   last_q;
   logic                   put;
   logic                   take;

   // Ready only with room for the held word and a new one
   assign in_if.ready = !(m_dst_full_i || m_dst_almost_full_i);
   assign take        = in_if.valid && in_if.ready;

   // A held word waits out a full FIFO
   assign put = pend_q && !m_dst_full_i;

   assign m_dst_putn_o = ~put;
   assign m_dst_o      = data_q;
   assign m_dst_last_o = last_q;
   assign put_last_o   = put && last_q;

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         pend_q <= 1'b0;
      end else if (take) begin
         pend_q <= 1'b1;
      end else if (put) begin
         pend_q <= 1'b0;
      end
   end

   // Output register
   always_ff @(posedge wb_clk_i) begin
      if (take) begin
         data_q <= in_if.data;
         last_q <= in_if.last;
      end
   end

   a_no_put_full: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      !m_dst_putn_o |-> !m_dst_full_i);

endmodule

/* source/dma_mod.sv */
// Descriptor-driven data mover
// Controller, source engine, fill stage and destination writer between
// a show-ahead source FIFO and a destination FIFO

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_mod import dma_pkg::*; (
   input  logic                   wb_clk_i,
   input  logic                   reset_i,
   input  logic                   enable_i,
   input  logic [`DMA_DC_W-1:0]   dc_i,
   input  logic [`DMA_DATA_W-1:0] m_src_i,
   input  logic                   m_src_last_i,
   input  logic                   m_src_empty_i,
   input  logic                   m_dst_full_i,
   input  logic                   m_dst_almost_full_i,
   output logic                   m_src_getn_o,
   output logic                   m_dst_putn_o,
   output logic [`DMA_DATA_W-1:0] m_dst_o,
   output logic                   m_dst_last_o,
   output logic                   m_endn_o
);

   dma_op_e               op;
   logic [`DMA_LEN_W-1:0] fill_len;
   logic                  start;
   logic                  src_done;
   logic                  put_last;

   // Engine to fill stage, fill stage to writer
   dma_stream_if src_st ();
   dma_stream_if dst_st ();

   dma_ctrl dma_ctrl_inst (
      .wb_clk_i   (wb_clk_i),
      .reset_i    (reset_i),
      .enable_i   (enable_i),
      .dc_i       (dc_i),
      .src_done_i (src_done),
      .put_last_i (put_last),
      .op_o       (op),
      .fill_len_o (fill_len),
      .start_o    (start),
      .m_endn_o   (m_endn_o)
   );

   dma_src_engine dma_src_engine_inst (
      .wb_clk_i      (wb_clk_i),
      .reset_i       (reset_i),
      .op_i          (op),
      .start_i       (start),
      .m_src_i       (m_src_i),
      .m_src_last_i  (m_src_last_i),
      .m_src_empty_i (m_src_empty_i),
      .m_src_getn_o  (m_src_getn_o),
      .src_done_o    (src_done),
      .out_if        (src_st.source)
   );

   dma_fill_stage dma_fill_stage_inst (
      .wb_clk_i   (wb_clk_i),
      .reset_i    (reset_i),
      .op_i       (op),
      .start_i    (start),
      .fill_len_i (fill_len),
      .in_if      (src_st.sink),
      .out_if     (dst_st.source)
   );

   dma_dst_writer dma_dst_writer_inst (
      .wb_clk_i            (wb_clk_i),
      .reset_i             (reset_i),
      .m_dst_full_i        (m_dst_full_i),
      .m_dst_almost_full_i (m_dst_almost_full_i),
      .in_if               (dst_st.sink),
      .m_dst_o             (m_dst_o),
      .m_dst_last_o        (m_dst_last_o),
      .m_dst_putn_o        (m_dst_putn_o),
      .put_last_o          (put_last)
   );

endmodule

/* testbench/tb_dma_mod.sv */
// Data mover testbench
// Random copy, fill, read and idle jobs against a source FIFO model and a
// destination recorder, with random back-pressure and a reference model

`timescale 1ns/10ps
`include "dma_params.svh"

module tb_dma_mod import dma_pkg::*; ();

   logic                   wb_clk_i = 1'b0;
   logic                   reset_i;
   logic                   enable_i;
   logic [`DMA_DC_W-1:0]   dc_i;
   logic [`DMA_DATA_W-1:0] m_src_i;
   logic                   m_src_last_i;
   logic                   m_src_empty_i;
   logic                   m_dst_full_i;
   logic                   m_dst_almost_full_i;
   logic                   m_src_getn_o;
   logic                   m_dst_putn_o;
   logic [`DMA_DATA_W-1:0] m_dst_o;
   logic                   m_dst_last_o;
   logic                   m_endn_o;

   logic [31:0]            lfsr = 32'hd0bf;
   logic                   stall_en = 1'b0;
   logic                   timed_out = 1'b0;
   logic [`DMA_DATA_W-1:0] src_q[$];
   logic                   src_last_q[$];
   logic [`DMA_DATA_W-1:0] dst_q[$];
   logic                   dst_last_q[$];
   int                     err_cnt = 0;
   int                     pop_cnt = 0;
   int                     put_cnt = 0;
   int                     endn_cnt = 0;
   int                     pass_cnt = 0;
   int                     fail_cnt = 0;

   always #5 wb_clk_i = ~wb_clk_i;

   dma_mod dma_mod_inst (
      .wb_clk_i            (wb_clk_i),
      .reset_i             (reset_i),
      .enable_i            (enable_i),
      .dc_i                (dc_i),
      .m_src_i             (m_src_i),
      .m_src_last_i        (m_src_last_i),
      .m_src_empty_i       (m_src_empty_i),
      .m_dst_full_i        (m_dst_full_i),
      .m_dst_almost_full_i (m_dst_almost_full_i),
      .m_src_getn_o        (m_src_getn_o),
      .m_dst_putn_o        (m_dst_putn_o),
      .m_dst_o             (m_dst_o),
      .m_dst_last_o        (m_dst_last_o),
      .m_endn_o            (m_endn_o)
   );

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_cond(input logic cond, input string msg);
      assert (cond) else begin
         $display("CHECK FAILED at %0t ns: %s", $time, msg);
         err_cnt++;
      end
   endtask

   // FIFO models react to the strobes seen at the rising edge
   task automatic sample_outputs();
      if (!reset_i) begin
         if (!m_src_getn_o) begin
            check_cond(!m_src_empty_i, "get strobe low while source FIFO empty");
            if (!m_src_empty_i) begin
               void'(src_q.pop_front());
               void'(src_last_q.pop_front());
            end
            pop_cnt++;
         end
         if (!m_dst_putn_o) begin
            check_cond(!m_dst_full_i, "put strobe low while destination FIFO full");
            dst_q.push_back(m_dst_o);
            dst_last_q.push_back(m_dst_last_o);
            put_cnt++;
         end
         if (!m_endn_o) begin
            endn_cnt++;
         end
      end
   endtask

   task automatic drive_inputs();
      logic hide;
      hide = 1'b0;
      m_dst_full_i        = 1'b0;
      m_dst_almost_full_i = 1'b0;
      if (stall_en) begin
         hide                = (rand_bits(2) == 0);
         m_dst_full_i        = (rand_bits(2) == 0);
         m_dst_almost_full_i = (rand_bits(2) == 0);
      end
      // Head word shown ahead unless a stall hides it as an empty FIFO
      m_src_empty_i = (src_q.size() == 0) || hide;
      m_src_i       = (src_q.size() > 0) ? src_q[0] : '0;
      m_src_last_i  = (src_q.size() > 0) ? src_last_q[0] : 1'b0;
   endtask

   task automatic step_cycle();
      @(posedge wb_clk_i);
      sample_outputs();
      @(negedge wb_clk_i);
      drive_inputs();
   endtask

   task automatic run_test(input int idx);
      dma_op_e                op;
      logic [1:0]             opv;
      logic [`DMA_DC_W-1:0]   dc;
      logic [31:0]            hi;
      logic [`DMA_DATA_W-1:0] exp_q[$];
      logic                   exp_last_q[$];
      int                     n;
      int                     len;
      int                     reps;
      int                     left;
      int                     cycles;
      int                     err0;
      int                     endn0;
      opv      = (idx <= 4) ? 2'(idx - 1) : 2'(rand_bits(2));
      op       = dma_op_e'(opv);
      stall_en = (idx > 4) && (rand_bits(1) == 1);
      n        = 1 + rand_bits(3);
      len      = rand_bits(3) % 7;
      err0     = err_cnt;
      endn0    = endn_cnt;
      dst_q.delete();
      dst_last_q.delete();
      for (int i = 0; i < n; i++) begin
         hi = rand_bits(32);
         src_q.push_back({hi, rand_bits(32)});
         src_last_q.push_back(i == n - 1);
      end
      // Expected destination sequence and words left in the source
      left = 0;
      case (op)
         OP_COPY: begin
            exp_q      = src_q;
            exp_last_q = src_last_q;
         end
         OP_FILL: begin
            reps = (len == 0) ? 1 : len;
            for (int i = 0; i < reps; i++) begin
               exp_q.push_back(src_q[0]);
               exp_last_q.push_back(i == reps - 1);
            end
            left = n - 1;
         end
         OP_NONE: left = n;
         default: left = 0;
      endcase
      dc = '0;
      dc[`DMA_OP_LSB +: `DMA_OP_W]   = opv;
      dc[`DMA_LEN_LSB +: `DMA_LEN_W] = `DMA_LEN_W'(len);
      step_cycle();
      dc_i     = dc;
      enable_i = 1'b1;
      cycles   = 0;
      while (endn_cnt == endn0 && cycles < 2000) begin
         step_cycle();
         cycles++;
      end
      if (endn_cnt == endn0) begin
         $display("TIMEOUT in test %0d: no end strobe within 2000 cycles", idx);
         err_cnt++;
         timed_out = 1'b1;
      end else begin
         // Enable held high after completion must not start a second job
         repeat (2 + rand_bits(2)) step_cycle();
         enable_i = 1'b0;
         repeat (3) step_cycle();
         check_cond(endn_cnt == endn0 + 1, $sformatf("test %0d end strobe low %0d cycles",
            idx, endn_cnt - endn0));
         check_cond(src_q.size() == left, $sformatf("test %0d left %0d source words, expected %0d",
            idx, src_q.size(), left));
         check_cond(dst_q.size() == exp_q.size(), $sformatf("test %0d got %0d puts, expected %0d",
            idx, dst_q.size(), exp_q.size()));
         for (int i = 0; i < dst_q.size() && i < exp_q.size(); i++) begin
            check_cond(dst_q[i] == exp_q[i] && dst_last_q[i] == exp_last_q[i],
               $sformatf("test %0d word %0d got %h last %0b, expected %h last %0b", idx, i,
               dst_q[i], dst_last_q[i], exp_q[i], exp_last_q[i]));
         end
      end
      src_q.delete();
      src_last_q.delete();
      if (err_cnt == err0) begin
         pass_cnt++;
      end else begin
         fail_cnt++;
      end
      $display("test %0d %s words %0d count %0d stall %0b: %s", idx, op.name(), n, len,
         stall_en, (err_cnt == err0) ? "PASS" : "FAIL");
      stall_en = 1'b0;
   endtask

   initial begin
      int idx;
      reset_i             = 1'b1;
      enable_i            = 1'b0;
      dc_i                = '0;
      m_src_i             = '0;
      m_src_last_i        = 1'b0;
      m_src_empty_i       = 1'b1;
      m_dst_full_i        = 1'b0;
      m_dst_almost_full_i = 1'b0;
      repeat (2) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      reset_i = 1'b0;

      // No strobe may move before enable even with a word waiting
      src_q.push_back(64'h0123_4567_89ab_cdef);
      src_last_q.push_back(1'b1);
      drive_inputs();
      repeat (6) step_cycle();
      check_cond(pop_cnt == 0 && put_cnt == 0 && endn_cnt == 0,
         "strobe active before enable was raised");
      if (err_cnt == 0) begin
         pass_cnt++;
      end else begin
         fail_cnt++;
      end
      $display("test 0 idle after reset: %s", (err_cnt == 0) ? "PASS" : "FAIL");
      src_q.delete();
      src_last_q.delete();

      idx = 1;
      while (idx <= 24 && !timed_out) begin
         run_test(idx);
         idx++;
      end
      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+source
source/dma_pkg.sv
source/dma_stream_if.sv
source/dma_ctrl.sv
source/dma_src_engine.sv
source/dma_fill_stage.sv
source/dma_dst_writer.sv
source/dma_mod.sv
testbench/tb_dma_mod.sv

/* Makefile */
# Verilator lint and simulation of the data mover

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps \
		-f sim.f --top-module dma_mod

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f sim.f --top-module tb_dma_mod --Mdir obj_dir
	@out=$$(./obj_dir/Vtb_dma_mod); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
